// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_dcache_top
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
src/bus_pkg.sv
src/dcache_pkg.sv
src/cache_bram.sv
src/bus_memory.sv
src/dcache.sv
src/dcache_top.sv
testbench/tb_dcache_top.sv

// File: src/bus_memory.sv
`timescale 1ns/1ps
`default_nettype none

module bus_memory
	import bus_pkg::*;
#(
	parameter int MEM_ADDR_BITS = 8,
	parameter int WAIT_STATES = 2
) (
	input  logic  i_clock,
	input  logic  i_rst_n,
	input  logic  i_bus_request,
	input  logic  i_bus_rw,
	input  addr_t i_bus_address,
	input  word_t i_bus_wdata,
	output logic  o_bus_ready,
	output word_t o_bus_rdata
);

	localparam int DEPTH = 1 << MEM_ADDR_BITS;
	localparam int CNT_BITS = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	word_t mem [DEPTH];

	logic [MEM_ADDR_BITS-1:0] mem_index;
	logic [CNT_BITS-1:0]      wait_count;

	// Higher address bits wrap around
	assign mem_index = i_bus_address[MEM_ADDR_BITS+1:2];

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Wait counter, restarted by a gap in the request or by ready
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wait_count <= '0;
			o_bus_ready <= 1'b0;
		end else if (!i_bus_request || o_bus_ready) begin
			wait_count <= '0;
			o_bus_ready <= 1'b0;
		end else if (wait_count == CNT_BITS'(WAIT_STATES)) begin
			o_bus_ready <= 1'b1;
		end else begin
			wait_count <= wait_count + 1'b1;
		end
	end

	// Read data lines up with ready; writes land on the ready edge
	always_ff @(posedge i_clock) begin
		o_bus_rdata <= mem[mem_index];
		if (o_bus_ready && i_bus_request && i_bus_rw) begin
			mem[mem_index] <= i_bus_wdata;
		end
	end

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// ======================================================================
	// Memory bus
	// ======================================================================

	// Data word on the CPU port and on the bus
	typedef logic [31:0] word_t;

	// Byte address, always word aligned
	typedef logic [31:0] addr_t;

endpackage

`default_nettype wire

// File: src/cache_bram.sv
`timescale 1ns/1ps
`default_nettype none

module cache_bram #(
	parameter int ADDR_BITS = 4,
	parameter int WIDTH = 64
) (
	input  logic                 i_clock,
	input  logic                 i_write,
	input  logic [ADDR_BITS-1:0] i_address,
	input  logic [WIDTH-1:0]     i_wdata,
	output logic [WIDTH-1:0]     o_rdata
);

	localparam int DEPTH = 1 << ADDR_BITS;

	logic [WIDTH-1:0] mem [DEPTH];

	// Read returns the old contents when the same entry is written
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_address] <= i_wdata;
		end
		o_rdata <= mem[i_address];
	end

endmodule

`default_nettype wire

// File: src/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache
	import bus_pkg::*, dcache_pkg::*;
#(
	parameter int INDEX_BITS = 4
) (
	input  logic  i_clock,
	input  logic  i_rst_n,

	// CPU side
	input  logic  i_request,
	input  logic  i_rw,
	input  logic  i_flush,
	input  logic  i_cacheable,
	input  addr_t i_address,
	input  word_t i_wdata,
	output logic  o_ready,
	output word_t o_rdata,

	// Memory bus
	output logic  o_bus_request,
	output logic  o_bus_rw,
	output addr_t o_bus_address,
	output word_t o_bus_wdata,
	input  logic  i_bus_ready,
	input  word_t i_bus_rdata
);

	// One past the last line, reached by the sweep counter
	localparam logic [INDEX_BITS:0] SWEEP_END = {1'b1, {INDEX_BITS{1'b0}}};

	dcache_state_t state;
	dcache_state_t state_next;

	logic [INDEX_BITS:0] sweep;
	logic [INDEX_BITS:0] sweep_next;

	logic                  cache_write;
	logic [INDEX_BITS-1:0] cache_index;
	line_t                 cache_wdata;
	line_t                 cache_rdata;

	logic   entry_valid;
	logic   entry_dirty;
	waddr_t entry_waddr;
	word_t  entry_data;
	addr_t  entry_address;
	waddr_t req_waddr;
	logic   entry_hit;

	function automatic line_t make_line(input word_t data, input waddr_t waddr,
			input logic dirty);
		make_line = {data, waddr, dirty, 1'b1};
	endfunction

	// Entry comes back one cycle after the index is presented
	cache_bram #(
		.ADDR_BITS(INDEX_BITS),
		.WIDTH($bits(line_t))
	) u_lines (
		.i_clock(i_clock),
		.i_write(cache_write),
		.i_address(cache_index),
		.i_wdata(cache_wdata),
		.o_rdata(cache_rdata)
	);

	assign entry_valid = cache_rdata[LINE_VALID_BIT];
	assign entry_dirty = cache_rdata[LINE_DIRTY_BIT];
	assign entry_waddr = cache_rdata[31:2];
	assign entry_data = cache_rdata[63:32];
	assign entry_address = {entry_waddr, 2'b00};
	assign req_waddr = i_address[31:2];
	assign entry_hit = entry_valid && (entry_waddr == req_waddr);

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= INITIALIZE;
			sweep <= '0;
		end else begin
			state <= state_next;
			sweep <= sweep_next;
		end
	end

	always_comb begin
		state_next = state;
		sweep_next = sweep;

		o_ready = 1'b0;
		o_rdata = '0;
		o_bus_request = 1'b0;
		o_bus_rw = 1'b0;
		o_bus_address = '0;
		o_bus_wdata = '0;

		cache_write = 1'b0;
		cache_wdata = '0;
		cache_index = i_address[INDEX_BITS+1:2];

		case (state)
			// ==============================================================
			// Startup and request decode
			// ==============================================================
			INITIALIZE: begin
				// Invalidate one line per cycle
				cache_write = 1'b1;
				cache_index = sweep[INDEX_BITS-1:0];
				if (sweep[INDEX_BITS-1:0] == '1) begin
					sweep_next = '0;
					state_next = IDLE;
				end else begin
					sweep_next = sweep + 1'b1;
				end
			end

			IDLE: begin
				if (i_request) begin
					if (i_flush) begin
						sweep_next = '0;
						state_next = FLUSH_SETUP;
					end else if (i_cacheable) begin
						state_next = i_rw ? WRITE_SETUP : READ_SETUP;
					end else begin
						// Uncached access starts on the bus right away
						o_bus_request = 1'b1;
						o_bus_rw = i_rw;
						o_bus_address = i_address;
						o_bus_wdata = i_wdata;
						state_next = PASS_THROUGH;
					end
				end
			end

			PASS_THROUGH: begin
				o_bus_request = 1'b1;
				o_bus_rw = i_rw;
				o_bus_address = i_address;
				o_bus_wdata = i_wdata;
				o_rdata = i_bus_rdata;
				if (i_bus_ready) begin
					o_ready = 1'b1;
					state_next = IDLE;
				end
			end

			// ==============================================================
			// Flush
			// ==============================================================
			FLUSH_SETUP: begin
				cache_index = sweep[INDEX_BITS-1:0];
				if (sweep < SWEEP_END) begin
					state_next = FLUSH_CHECK;
				end else begin
					sweep_next = '0;
					o_ready = 1'b1;
					state_next = IDLE;
				end
			end

			FLUSH_CHECK: begin
				cache_index = sweep[INDEX_BITS-1:0];
				if (entry_dirty) begin
					o_bus_request = 1'b1;
					o_bus_rw = 1'b1;
					o_bus_address = entry_address;
					o_bus_wdata = entry_data;
					state_next = FLUSH_WRITE;
				end else begin
					sweep_next = sweep + 1'b1;
					state_next = FLUSH_SETUP;
				end
			end

			FLUSH_WRITE: begin
				cache_index = sweep[INDEX_BITS-1:0];
				o_bus_request = 1'b1;
				o_bus_rw = 1'b1;
				o_bus_address = entry_address;
				o_bus_wdata = entry_data;
				if (i_bus_ready) begin
					// Line stays valid, now clean
					cache_write = 1'b1;
					cache_wdata = make_line(entry_data, entry_waddr, 1'b0);
					sweep_next = sweep + 1'b1;
					state_next = FLUSH_SETUP;
				end
			end

			// ==============================================================
			// Cached write
			// ==============================================================
			WRITE_SETUP: begin
				if (entry_dirty && (entry_waddr != req_waddr)) begin
					o_bus_request = 1'b1;
					o_bus_rw = 1'b1;
					o_bus_address = entry_address;
					o_bus_wdata = entry_data;
					state_next = WRITE_WAIT;
				end else begin
					cache_write = 1'b1;
					cache_wdata = make_line(i_wdata, req_waddr, 1'b1);
					o_ready = 1'b1;
					state_next = IDLE;
				end
			end

			WRITE_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_rw = 1'b1;
				o_bus_address = entry_address;
				o_bus_wdata = entry_data;
				if (i_bus_ready) begin
					cache_write = 1'b1;
					cache_wdata = make_line(i_wdata, req_waddr, 1'b1);
					o_ready = 1'b1;
					state_next = IDLE;
				end
			end

			// ==============================================================
			// Cached read
			// ==============================================================
			READ_SETUP: begin
				o_rdata = entry_data;
				if (entry_hit) begin
					o_ready = 1'b1;
					state_next = IDLE;
				end else if (entry_dirty) begin
					o_bus_request = 1'b1;
					o_bus_rw = 1'b1;
					o_bus_address = entry_address;
					o_bus_wdata = entry_data;
					state_next = READ_WB_WAIT;
				end else begin
					o_bus_request = 1'b1;
					o_bus_address = i_address;
					state_next = READ_BUS_WAIT;
				end
			end

			// Victim goes out before the refill
			READ_WB_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_rw = 1'b1;
				o_bus_address = entry_address;
				o_bus_wdata = entry_data;
				if (i_bus_ready) begin
					state_next = READ_BUS_WAIT;
				end
			end

			READ_BUS_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_address = i_address;
				o_rdata = i_bus_rdata;
				if (i_bus_ready) begin
					cache_write = 1'b1;
					cache_wdata = make_line(i_bus_rdata, req_waddr, 1'b0);
					o_ready = 1'b1;
					state_next = IDLE;
				end
			end

			default: begin
				state_next = INITIALIZE;
				sweep_next = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// ======================================================================
	// Cache line layout
	// ======================================================================

	// {data[63:32], word address[31:2], dirty, valid}
	typedef logic [63:0] line_t;

	// Word address stored in place of a tag
	typedef logic [29:0] waddr_t;

	localparam int LINE_VALID_BIT = 0;
	localparam int LINE_DIRTY_BIT = 1;

	// Controller states
	typedef enum logic [3:0] {
		INITIALIZE,
		IDLE,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT
	} dcache_state_t;

endpackage

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
	import bus_pkg::*;
#(
	parameter int INDEX_BITS = 4,
	parameter int MEM_ADDR_BITS = 8,
	parameter int WAIT_STATES = 2
) (
	input  logic  i_clock,
	input  logic  i_rst_n,
	input  logic  i_request,
	input  logic  i_rw,
	input  logic  i_flush,
	input  logic  i_cacheable,
	input  addr_t i_address,
	input  word_t i_wdata,
	output logic  o_ready,
	output word_t o_rdata
);

	// Bus between cache and main memory
	logic  bus_request;
	logic  bus_rw;
	addr_t bus_address;
	word_t bus_wdata;
	logic  bus_ready;
	word_t bus_rdata;

	dcache #(
		.INDEX_BITS(INDEX_BITS)
	) u_dcache (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_flush(i_flush),
		.i_cacheable(i_cacheable),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	bus_memory #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.WAIT_STATES(WAIT_STATES)
	) u_bus_memory (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_bus_request(bus_request),
		.i_bus_rw(bus_rw),
		.i_bus_address(bus_address),
		.i_bus_wdata(bus_wdata),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata)
	);

endmodule

`default_nettype wire

// File: testbench/tb_dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top
	import bus_pkg::*;
();

	localparam int NUM_OPS = 400;
	localparam int CYCLE_LIMIT = NUM_OPS * 64;
	localparam int DONE_LIMIT = 256;
	localparam int POOL_WORDS = 64;
	// Uncached traffic lives in its own window of main memory
	localparam int UNCACHED_BASE = 128;

	logic  clock;
	logic  rst_n;
	logic  request;
	logic  rw;
	logic  flush;
	logic  cacheable;
	addr_t address;
	word_t wdata;
	logic  ready;
	word_t rdata;

	// Coherent memory image and the words written through the cache
	word_t model [256];
	bit    dirty_set [POOL_WORDS];

	int data_errors;
	int done_errors;
	int stray_errors;
	int reads_checked;
	int cycle_count;

	dcache_top u_dcache_top (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_request(request),
		.i_rw(rw),
		.i_flush(flush),
		.i_cacheable(cacheable),
		.i_address(address),
		.i_wdata(wdata),
		.o_ready(ready),
		.o_rdata(rdata)
	);

	always #20 clock = ~clock;

	// ======================================================================
	// Checks
	// ======================================================================

	task automatic check_word(input word_t actual, input word_t expected,
			input addr_t addr, input string what);
		reads_checked++;
		if (actual !== expected) begin
			data_errors++;
			$display("ERR %0t: %s at 0x%08h returned 0x%08h, expected 0x%08h",
				$time, what, addr, actual, expected);
		end
	endtask

	// Sampled on the falling edge, where o_ready is settled
	task automatic check_done(input addr_t addr, output word_t data);
		int   waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		data = '0;
		while (!seen && waited < DONE_LIMIT) begin
			@(negedge clock);
			waited++;
			if (ready) begin
				seen = 1'b1;
				data = rdata;
			end
		end
		if (!seen) begin
			done_errors++;
			$display("Request to address 0x%08h got no o_ready within %0d cycles",
				addr, DONE_LIMIT);
		end
	endtask

	// A ready pulse with no request pending means a second or stray completion
	always @(negedge clock) begin
		if (rst_n && ready && !request) begin
			stray_errors++;
			$display("Unexpected o_ready with no request pending at %0t", $time);
		end
	end

	// ======================================================================
	// Request helpers
	// ======================================================================

	function automatic addr_t word_address(input int w);
		return addr_t'(w) << 2;
	endfunction

	task automatic run_request(input logic op_write, input logic op_cached,
			input logic op_flush, input addr_t addr, input word_t data,
			output word_t result);
		@(posedge clock);
		request <= 1'b1;
		rw <= op_write;
		cacheable <= op_cached;
		flush <= op_flush;
		address <= addr;
		wdata <= data;
		check_done(addr, result);
		// Release for one idle cycle before the next request
		@(posedge clock);
		request <= 1'b0;
		flush <= 1'b0;
	endtask

	task automatic write_cached(input int w, input word_t data);
		word_t unused;
		run_request(1'b1, 1'b1, 1'b0, word_address(w), data, unused);
		model[w] = data;
		dirty_set[w] = 1'b1;
	endtask

	task automatic read_cached(input int w);
		word_t got;
		run_request(1'b0, 1'b1, 1'b0, word_address(w), '0, got);
		check_word(got, model[w], word_address(w), "Cached read");
	endtask

	task automatic write_uncached(input int w, input word_t data);
		word_t unused;
		run_request(1'b1, 1'b0, 1'b0, word_address(w), data, unused);
		model[w] = data;
	endtask

	task automatic read_uncached(input int w);
		word_t got;
		run_request(1'b0, 1'b0, 1'b0, word_address(w), '0, got);
		check_word(got, model[w], word_address(w), "Uncached read");
	endtask

	// Every word written since the last flush must now be in memory
	task automatic flush_and_verify();
		word_t unused;
		run_request(1'b0, 1'b0, 1'b1, '0, '0, unused);
		for (int w = 0; w < POOL_WORDS; w++) begin
			if (dirty_set[w]) begin
				read_uncached(w);
				dirty_set[w] = 1'b0;
			end
		end
	endtask

	// A dirty line held across a second reset must not hit afterwards
	task automatic reset_with_dirty_line(input int w);
		word_t old_value;
		old_value = model[w];
		write_cached(w, $urandom() | 32'h1);
		@(posedge clock);
		rst_n <= 1'b0;
		repeat (3) @(posedge clock);
		rst_n <= 1'b1;
		// Memory never saw the dirty word
		model[w] = old_value;
		dirty_set[w] = 1'b0;
		read_cached(w);
	endtask

	// ======================================================================
	// Run limit
	// ======================================================================

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Run stopped: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial begin
		int    kind;
		int    w;
		int    w_a;
		int    w_b;
		word_t d;

		void'($urandom(40012));
		clock = 1'b0;
		rst_n = 1'b0;
		request = 1'b0;
		rw = 1'b0;
		flush = 1'b0;
		cacheable = 1'b0;
		address = '0;
		wdata = '0;
		data_errors = 0;
		done_errors = 0;
		stray_errors = 0;
		reads_checked = 0;
		for (int i = 0; i < 256; i++) begin
			model[i] = '0;
		end
		for (int i = 0; i < POOL_WORDS; i++) begin
			dirty_set[i] = 1'b0;
		end

		repeat (3) @(posedge clock);
		rst_n <= 1'b1;

		// First read goes in while lines are still being invalidated
		read_cached($urandom_range(0, POOL_WORDS - 1));

		// Only clean lines are cached at this point
		reset_with_dirty_line($urandom_range(0, POOL_WORDS - 1));

		// Two words sharing one line
		w_a = $urandom_range(0, POOL_WORDS - 1);
		w_b = w_a ^ 16;
		for (int i = 0; i < 4; i++) begin
			write_cached(w_a, $urandom());
			write_cached(w_b, $urandom());
		end
		read_cached(w_a);
		read_cached(w_b);

		// Pass-through window
		for (int i = 0; i < 8; i++) begin
			write_uncached(UNCACHED_BASE + i * 5, $urandom());
		end
		for (int i = 0; i < 8; i++) begin
			read_uncached(UNCACHED_BASE + i * 5);
		end

		for (int op = 0; op < NUM_OPS; op++) begin
			kind = $urandom_range(0, 99);
			w = $urandom_range(0, POOL_WORDS - 1);
			d = $urandom();
			if (kind < 40) begin
				write_cached(w, d);
			end else if (kind < 75) begin
				read_cached(w);
			end else if (kind < 85) begin
				write_uncached(UNCACHED_BASE + w, d);
			end else if (kind < 97) begin
				// Memory is stale for words still held dirty
				if (dirty_set[w]) begin
					w = UNCACHED_BASE + $urandom_range(0, POOL_WORDS - 1);
				end
				read_uncached(w);
			end else begin
				flush_and_verify();
			end
		end

		flush_and_verify();

		$write("Summary: %0d reads compared, %0d data errors, ",
			reads_checked, data_errors);
		$display("%0d completion errors, %0d stray ready pulses",
			done_errors, stray_errors);
		if (data_errors + done_errors + stray_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
